// File: hdr_frame_pkg.sv
package hdr_frame_pkg;

  // stream geometry
  localparam int DATA_WIDTH = 128;
  localparam int HDR_WIDTH  = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int HDR_STRB   = HDR_WIDTH / 8;

  // side-band tags
  localparam int DEST_WIDTH = 8;
  localparam int USER_WIDTH = 8;

  // entries in each header queue and in the rx beat buffer
  localparam int HDR_FIFO_DEPTH = 4;

  // one header word, prepended on tx and extracted on rx
  typedef logic [HDR_WIDTH-1:0] hdr_t;

  // one stream beat, 161 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] tdata;
    logic [STRB_WIDTH-1:0] tkeep;
    logic [DEST_WIDTH-1:0] tdest;
    logic [USER_WIDTH-1:0] tuser;
    logic                  tlast;
  } axis_beat_t;

  // framing FSM, shared by adder and remover
  // ST_HDR waits for or handles the header beat
  // ST_MID passes the shifted middle beats
  // ST_LST sends the leftover half as a tail beat
  typedef enum logic [1:0] {
    ST_HDR,
    ST_MID,
    ST_LST
  } frame_state_t;

endpackage

// File: stream_fifo.sv
module stream_fifo #(
  parameter type payload_t = hdr_frame_pkg::hdr_t,
  parameter int  DEPTH     = hdr_frame_pkg::HDR_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // storage, no reset needed on payload
  payload_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  // occupancy, one bit wider than the pointers
  logic [$clog2(DEPTH):0]   count;
  logic                     wr_en;
  logic                     rd_en;

  // head entry always visible, no fall-through
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  // full fifo still takes a beat when one leaves in the same cycle
  assign in_ready = (count != ($clog2(DEPTH)+1)'(DEPTH)) || out_ready;

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH-1
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // write and read together leave the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: header_adder.sv
module header_adder (
  input  logic                      clk,
  input  logic                      rst,
  input  hdr_frame_pkg::axis_beat_t s_beat,
  input  logic                      s_valid,
  output logic                      s_ready,
  input  hdr_frame_pkg::hdr_t       hdr,
  input  logic                      hdr_valid,
  output logic                      hdr_ready,
  output hdr_frame_pkg::axis_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  hdr_frame_pkg::frame_state_t state;

  // upper half of the last accepted input beat
  logic [hdr_frame_pkg::HDR_WIDTH-1:0]  hi_data;
  logic [hdr_frame_pkg::HDR_STRB-1:0]   hi_keep;
  // side-band of the first beat, reused for the tail
  logic [hdr_frame_pkg::DEST_WIDTH-1:0] hold_dest;
  logic [hdr_frame_pkg::USER_WIDTH-1:0] hold_user;
  logic                                 upper_used;
  logic                                 s_xfer;

  // any byte left over above the half-beat shift
  assign upper_used =
    |s_beat.tkeep[hdr_frame_pkg::STRB_WIDTH-1 -: hdr_frame_pkg::HDR_STRB];
  assign s_xfer = s_valid && s_ready;

  // header popped together with the first payload beat
  assign hdr_ready = (state == hdr_frame_pkg::ST_HDR) && s_valid && m_ready;

  always_comb begin
    case (state)
      hdr_frame_pkg::ST_HDR: s_ready = m_ready && hdr_valid;
      hdr_frame_pkg::ST_MID: s_ready = m_ready;
      // tail beat comes from registers, input held off
      default:               s_ready = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      hdr_frame_pkg::ST_HDR: m_valid = s_valid && hdr_valid;
      hdr_frame_pkg::ST_MID: m_valid = s_valid;
      default:               m_valid = 1'b1;
    endcase
  end

  always_comb begin
    m_beat.tdest = hold_dest;
    m_beat.tuser = hold_user;
    case (state)
      hdr_frame_pkg::ST_HDR: begin
        // header in the low half, payload low half above it
        m_beat.tdata = {s_beat.tdata[hdr_frame_pkg::DATA_WIDTH-hdr_frame_pkg::HDR_WIDTH-1:0],
                        hdr};
        m_beat.tkeep = {s_beat.tkeep[hdr_frame_pkg::STRB_WIDTH-hdr_frame_pkg::HDR_STRB-1:0],
                        {hdr_frame_pkg::HDR_STRB{1'b1}}};
        m_beat.tdest = s_beat.tdest;
        m_beat.tuser = s_beat.tuser;
        m_beat.tlast = s_beat.tlast && !upper_used;
      end
      hdr_frame_pkg::ST_MID: begin
        // current low half over the previous upper half
        m_beat.tdata = {s_beat.tdata[hdr_frame_pkg::DATA_WIDTH-hdr_frame_pkg::HDR_WIDTH-1:0],
                        hi_data};
        m_beat.tkeep = {s_beat.tkeep[hdr_frame_pkg::STRB_WIDTH-hdr_frame_pkg::HDR_STRB-1:0],
                        hi_keep};
        m_beat.tlast = s_beat.tlast && !upper_used;
      end
      default: begin
        // tail, leftover upper half only
        m_beat.tdata = {{(hdr_frame_pkg::DATA_WIDTH-hdr_frame_pkg::HDR_WIDTH){1'b0}}, hi_data};
        m_beat.tkeep = {{(hdr_frame_pkg::STRB_WIDTH-hdr_frame_pkg::HDR_STRB){1'b0}}, hi_keep};
        m_beat.tlast = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= hdr_frame_pkg::ST_HDR;
    end else begin
      case (state)
        hdr_frame_pkg::ST_HDR, hdr_frame_pkg::ST_MID: begin
          if (s_xfer && s_beat.tlast) begin
            state <= upper_used ? hdr_frame_pkg::ST_LST : hdr_frame_pkg::ST_HDR;
          end else if (s_xfer) begin
            state <= hdr_frame_pkg::ST_MID;
          end
        end
        default: begin
          if (m_ready) begin
            state <= hdr_frame_pkg::ST_HDR;
          end
        end
      endcase
    end
  end

  // capture only on a real transfer so stalls keep the old half
  always_ff @(posedge clk) begin
    if (s_xfer) begin
      hi_data <= s_beat.tdata[hdr_frame_pkg::DATA_WIDTH-1 -: hdr_frame_pkg::HDR_WIDTH];
      hi_keep <= s_beat.tkeep[hdr_frame_pkg::STRB_WIDTH-1 -: hdr_frame_pkg::HDR_STRB];
    end
    if (s_xfer && state == hdr_frame_pkg::ST_HDR) begin
      hold_dest <= s_beat.tdest;
      hold_user <= s_beat.tuser;
    end
  end

endmodule

// File: header_remover.sv
module header_remover (
  input  logic                      clk,
  input  logic                      rst,
  input  hdr_frame_pkg::axis_beat_t s_beat,
  input  logic                      s_valid,
  output logic                      s_ready,
  output hdr_frame_pkg::hdr_t       hdr,
  output logic                      hdr_valid,
  input  logic                      hdr_ready,
  output hdr_frame_pkg::axis_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  hdr_frame_pkg::frame_state_t state;

  // upper half of the last accepted framed beat
  logic [hdr_frame_pkg::DATA_WIDTH-hdr_frame_pkg::HDR_WIDTH-1:0] hi_data;
  logic [hdr_frame_pkg::STRB_WIDTH-hdr_frame_pkg::HDR_STRB-1:0]  hi_keep;
  // side-band from the header beat
  logic [hdr_frame_pkg::DEST_WIDTH-1:0]                          hold_dest;
  logic [hdr_frame_pkg::USER_WIDTH-1:0]                          hold_user;
  logic                                                          upper_used;
  logic                                                          s_xfer;

  // payload bytes above the header position
  assign upper_used =
    |s_beat.tkeep[hdr_frame_pkg::STRB_WIDTH-1:hdr_frame_pkg::HDR_STRB];
  assign s_xfer = s_valid && s_ready;

  // header sits in the low half of the first beat
  assign hdr       = s_beat.tdata[hdr_frame_pkg::HDR_WIDTH-1:0];
  assign hdr_valid = (state == hdr_frame_pkg::ST_HDR) && s_valid;

  always_comb begin
    case (state)
      // first beat waits for room in the header queue
      hdr_frame_pkg::ST_HDR: s_ready = hdr_ready;
      hdr_frame_pkg::ST_MID: s_ready = m_ready;
      // tail drains from registers
      default:               s_ready = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      // header beat gives no payload output
      hdr_frame_pkg::ST_HDR: m_valid = 1'b0;
      hdr_frame_pkg::ST_MID: m_valid = s_valid;
      default:               m_valid = 1'b1;
    endcase
  end

  always_comb begin
    m_beat.tdest = hold_dest;
    m_beat.tuser = hold_user;
    if (state == hdr_frame_pkg::ST_LST) begin
      // leftover upper half moved down, nothing above it
      m_beat.tdata = {{hdr_frame_pkg::HDR_WIDTH{1'b0}}, hi_data};
      m_beat.tkeep = {{hdr_frame_pkg::HDR_STRB{1'b0}}, hi_keep};
      m_beat.tlast = 1'b1;
    end else begin
      // own low half above the stored upper half, undoes the adder shift
      m_beat.tdata = {s_beat.tdata[hdr_frame_pkg::HDR_WIDTH-1:0], hi_data};
      m_beat.tkeep = {s_beat.tkeep[hdr_frame_pkg::HDR_STRB-1:0], hi_keep};
      m_beat.tlast = s_beat.tlast && !upper_used;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= hdr_frame_pkg::ST_HDR;
    end else begin
      case (state)
        hdr_frame_pkg::ST_HDR: begin
          if (s_xfer && s_beat.tlast) begin
            // single-beat frame, payload only in the upper half
            state <= upper_used ? hdr_frame_pkg::ST_LST : hdr_frame_pkg::ST_HDR;
          end else if (s_xfer) begin
            state <= hdr_frame_pkg::ST_MID;
          end
        end
        hdr_frame_pkg::ST_MID: begin
          if (s_xfer && s_beat.tlast) begin
            state <= upper_used ? hdr_frame_pkg::ST_LST : hdr_frame_pkg::ST_HDR;
          end
        end
        default: begin
          if (m_ready) begin
            state <= hdr_frame_pkg::ST_HDR;
          end
        end
      endcase
    end
  end

  // upper half kept across stalls, updated on transfer only
  always_ff @(posedge clk) begin
    if (s_xfer) begin
      hi_data <= s_beat.tdata[hdr_frame_pkg::DATA_WIDTH-1:hdr_frame_pkg::HDR_WIDTH];
      hi_keep <= s_beat.tkeep[hdr_frame_pkg::STRB_WIDTH-1:hdr_frame_pkg::HDR_STRB];
    end
    if (s_xfer && state == hdr_frame_pkg::ST_HDR) begin
      hold_dest <= s_beat.tdest;
      hold_user <= s_beat.tuser;
    end
  end

endmodule

// File: hdr_frame_top.sv
module hdr_frame_top (
  input  logic                      clk,
  input  logic                      rst,
  // tx header and payload in, framed stream out
  input  hdr_frame_pkg::hdr_t       tx_hdr,
  input  logic                      tx_hdr_valid,
  output logic                      tx_hdr_ready,
  input  hdr_frame_pkg::axis_beat_t tx_in,
  input  logic                      tx_in_valid,
  output logic                      tx_in_ready,
  output hdr_frame_pkg::axis_beat_t tx_out,
  output logic                      tx_out_valid,
  input  logic                      tx_out_ready,
  // rx framed stream in, payload and header out
  input  hdr_frame_pkg::axis_beat_t rx_in,
  input  logic                      rx_in_valid,
  output logic                      rx_in_ready,
  output hdr_frame_pkg::axis_beat_t rx_out,
  output logic                      rx_out_valid,
  input  logic                      rx_out_ready,
  output hdr_frame_pkg::hdr_t       rx_hdr,
  output logic                      rx_hdr_valid,
  input  logic                      rx_hdr_ready
);

  // tx header queue to adder
  hdr_frame_pkg::hdr_t       hq_hdr;
  logic                      hq_valid;
  logic                      hq_ready;
  // remover to rx header queue
  hdr_frame_pkg::hdr_t       rm_hdr;
  logic                      rm_hdr_valid;
  logic                      rm_hdr_ready;
  // remover to rx beat buffer
  hdr_frame_pkg::axis_beat_t rm_beat;
  logic                      rm_valid;
  logic                      rm_ready;

  stream_fifo #(
    .payload_t (hdr_frame_pkg::hdr_t),
    .DEPTH     (hdr_frame_pkg::HDR_FIFO_DEPTH)
  ) u_tx_hdr_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (tx_hdr),
    .in_valid  (tx_hdr_valid),
    .in_ready  (tx_hdr_ready),
    .out_data  (hq_hdr),
    .out_valid (hq_valid),
    .out_ready (hq_ready)
  );

  header_adder u_adder (
    .clk       (clk),
    .rst       (rst),
    .s_beat    (tx_in),
    .s_valid   (tx_in_valid),
    .s_ready   (tx_in_ready),
    .hdr       (hq_hdr),
    .hdr_valid (hq_valid),
    .hdr_ready (hq_ready),
    .m_beat    (tx_out),
    .m_valid   (tx_out_valid),
    .m_ready   (tx_out_ready)
  );

  header_remover u_remover (
    .clk       (clk),
    .rst       (rst),
    .s_beat    (rx_in),
    .s_valid   (rx_in_valid),
    .s_ready   (rx_in_ready),
    .hdr       (rm_hdr),
    .hdr_valid (rm_hdr_valid),
    .hdr_ready (rm_hdr_ready),
    .m_beat    (rm_beat),
    .m_valid   (rm_valid),
    .m_ready   (rm_ready)
  );

  stream_fifo #(
    .payload_t (hdr_frame_pkg::hdr_t),
    .DEPTH     (hdr_frame_pkg::HDR_FIFO_DEPTH)
  ) u_rx_hdr_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (rm_hdr),
    .in_valid  (rm_hdr_valid),
    .in_ready  (rm_hdr_ready),
    .out_data  (rx_hdr),
    .out_valid (rx_hdr_valid),
    .out_ready (rx_hdr_ready)
  );

  // output buffer, same depth as the header queues
  stream_fifo #(
    .payload_t (hdr_frame_pkg::axis_beat_t),
    .DEPTH     (hdr_frame_pkg::HDR_FIFO_DEPTH)
  ) u_rx_beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (rm_beat),
    .in_valid  (rm_valid),
    .in_ready  (rm_ready),
    .out_data  (rx_out),
    .out_valid (rx_out_valid),
    .out_ready (rx_out_ready)
  );

endmodule

// File: hdr_frame_assertions.sv
module hdr_frame_assertions (
  input logic                      clk,
  input logic                      rst,
  input hdr_frame_pkg::axis_beat_t tx_out,
  input logic                      tx_out_valid,
  input logic                      tx_out_ready,
  input hdr_frame_pkg::axis_beat_t rx_out,
  input logic                      rx_out_valid,
  input logic                      rx_out_ready,
  input hdr_frame_pkg::hdr_t       rx_hdr,
  input logic                      rx_hdr_valid,
  input logic                      rx_hdr_ready
);

  // failures so far, read by the testbench at the end
  int fail_count = 0;

  // framed beat held with its data until taken
  tx_hold: assert property (@(posedge clk) disable iff (rst)
    tx_out_valid && !tx_out_ready |=> tx_out_valid && $stable(tx_out))
    else begin
      $error("tx_out dropped valid or changed data while stalled");
      fail_count++;
    end

  // rx payload buffer head
  rx_hold: assert property (@(posedge clk) disable iff (rst)
    rx_out_valid && !rx_out_ready |=> rx_out_valid && $stable(rx_out))
    else begin
      $error("rx_out dropped valid or changed data while stalled");
      fail_count++;
    end

  // rx header queue head
  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    rx_hdr_valid && !rx_hdr_ready |=> rx_hdr_valid && $stable(rx_hdr))
    else begin
      $error("rx_hdr dropped valid or changed data while stalled");
      fail_count++;
    end

endmodule

bind hdr_frame_top hdr_frame_assertions u_assertions (
  .clk          (clk),
  .rst          (rst),
  .tx_out       (tx_out),
  .tx_out_valid (tx_out_valid),
  .tx_out_ready (tx_out_ready),
  .rx_out       (rx_out),
  .rx_out_valid (rx_out_valid),
  .rx_out_ready (rx_out_ready),
  .rx_hdr       (rx_hdr),
  .rx_hdr_valid (rx_hdr_valid),
  .rx_hdr_ready (rx_hdr_ready)
);

// File: tb_hdr_frame.sv
module tb_hdr_frame;

  typedef enum int {
    T_RESET,
    T_FRAME,
    T_SIDE,
    T_TRIP,
    T_HDR,
    T_BP,
    T_COUNT
  } test_t;

  logic                      clk;
  logic                      rst;
  hdr_frame_pkg::hdr_t       tx_hdr;
  logic                      tx_hdr_valid;
  logic                      tx_hdr_ready;
  hdr_frame_pkg::axis_beat_t tx_in;
  logic                      tx_in_valid;
  logic                      tx_in_ready;
  hdr_frame_pkg::axis_beat_t tx_out;
  logic                      tx_out_valid;
  logic                      tx_out_ready;
  hdr_frame_pkg::axis_beat_t rx_in;
  logic                      rx_in_valid;
  logic                      rx_in_ready;
  hdr_frame_pkg::axis_beat_t rx_out;
  logic                      rx_out_valid;
  logic                      rx_out_ready;
  hdr_frame_pkg::hdr_t       rx_hdr;
  logic                      rx_hdr_valid;
  logic                      rx_hdr_ready;

  // raw file words with tkeep above tdata
  logic [hdr_frame_pkg::STRB_WIDTH+hdr_frame_pkg::DATA_WIDTH-1:0] stim_mem [64];

  // per packet
  hdr_frame_pkg::hdr_t                  pkt_hdr [$];
  logic [hdr_frame_pkg::DEST_WIDTH-1:0] pkt_dest [$];
  logic [hdr_frame_pkg::USER_WIDTH-1:0] pkt_user [$];
  int                                   pkt_nin [$];
  int                                   pkt_nout [$];
  // flat beat lists for input payload and framed stream
  logic [hdr_frame_pkg::DATA_WIDTH-1:0] in_data [$];
  logic [hdr_frame_pkg::STRB_WIDTH-1:0] in_keep [$];
  logic [hdr_frame_pkg::DATA_WIDTH-1:0] exp_data [$];
  logic [hdr_frame_pkg::STRB_WIDTH-1:0] exp_keep [$];

  string test_name [T_COUNT] = '{"reset", "framing", "side-band", "round-trip", "header",
                                 "back-pressure"};
  int    test_err [T_COUNT];
  int    n_pkts;
  int    n_in;
  int    n_exp;
  int    limit_cycles;
  int    checks;
  bit    running;
  // monitor positions
  int    tx_idx;
  int    tx_pkt;
  int    tx_beat;
  int    rx_idx;
  int    rx_pkt;
  int    rx_beat;
  int    rx_last_seen;
  int    rh_idx;

  // tx framed stream looped straight into rx
  assign rx_in        = tx_out;
  assign rx_in_valid  = tx_out_valid;
  assign tx_out_ready = rx_in_ready;

  hdr_frame_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input test_t t, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name[t], what, exp, act);
      test_err[t]++;
    end
  endtask

  task automatic load_stimulus();
    int ptr;
    int nin;
    int nout;
    ptr = 0;
    $readmemh("hdr_frame_stimulus.txt", stim_mem);
    // zero beat count marks the end of the list
    while (ptr < 64 && stim_mem[ptr][143:136] != 8'h00) begin
      nin  = int'(stim_mem[ptr][143:136]);
      nout = int'(stim_mem[ptr][135:128]);
      pkt_dest.push_back(stim_mem[ptr][127:120]);
      pkt_user.push_back(stim_mem[ptr][119:112]);
      pkt_hdr.push_back(stim_mem[ptr][63:0]);
      pkt_nin.push_back(nin);
      pkt_nout.push_back(nout);
      for (int i = 1; i <= nin; i++) begin
        in_data.push_back(stim_mem[ptr+i][127:0]);
        in_keep.push_back(stim_mem[ptr+i][143:128]);
      end
      for (int i = 1; i <= nout; i++) begin
        exp_data.push_back(stim_mem[ptr+nin+i][127:0]);
        exp_keep.push_back(stim_mem[ptr+nin+i][143:128]);
      end
      ptr += 1 + nin + nout;
    end
    n_pkts = pkt_hdr.size();
    n_in   = in_data.size();
    n_exp  = exp_data.size();
    limit_cycles = (n_in + n_exp) * 20 + 200;
  endtask

  task automatic drive_headers();
    for (int p = 0; p < n_pkts; p++) begin
      @(negedge clk);
      tx_hdr       = pkt_hdr[p];
      tx_hdr_valid = 1'b1;
      @(posedge clk);
      while (!tx_hdr_ready) @(posedge clk);
    end
    @(negedge clk);
    tx_hdr_valid = 1'b0;
  endtask

  task automatic drive_beats();
    int idx;
    idx = 0;
    for (int p = 0; p < n_pkts; p++) begin
      for (int b = 0; b < pkt_nin[p]; b++) begin
        @(negedge clk);
        tx_in.tdata = in_data[idx];
        tx_in.tkeep = in_keep[idx];
        tx_in.tdest = pkt_dest[p];
        tx_in.tuser = pkt_user[p];
        tx_in.tlast = (b == pkt_nin[p] - 1);
        tx_in_valid = 1'b1;
        @(posedge clk);
        while (!tx_in_ready) @(posedge clk);
        idx++;
      end
      @(negedge clk);
      tx_in_valid = 1'b0;
      // short idle gap between packets
      repeat ($urandom % 3) @(negedge clk);
    end
  endtask

  // random stalls on both rx outputs
  task automatic stall_outputs();
    forever begin
      @(negedge clk);
      rx_out_ready = ($urandom % 4) != 0;
      rx_hdr_ready = ($urandom % 2) != 0;
    end
  endtask

  task automatic check_tx_beat();
    string tag;
    logic  exp_last;
    checks++;
    assert (tx_idx < n_exp) else begin
      $display("tx_out carried more beats than the stimulus file holds");
      test_err[T_BP]++;
    end
    if (tx_idx < n_exp) begin
      tag      = $sformatf("pkt%0d tx beat%0d", tx_pkt, tx_beat);
      exp_last = (tx_beat == pkt_nout[tx_pkt] - 1);
      check_value(T_FRAME, {tag, " tdata"}, exp_data[tx_idx], tx_out.tdata);
      check_value(T_FRAME, {tag, " tkeep"}, 128'(exp_keep[tx_idx]), 128'(tx_out.tkeep));
      check_value(T_FRAME, {tag, " tlast"}, 128'(exp_last), 128'(tx_out.tlast));
      check_value(T_SIDE, {tag, " tdest"}, 128'(pkt_dest[tx_pkt]), 128'(tx_out.tdest));
      check_value(T_SIDE, {tag, " tuser"}, 128'(pkt_user[tx_pkt]), 128'(tx_out.tuser));
      if (exp_last) begin
        tx_pkt++;
        tx_beat = 0;
      end else begin
        tx_beat++;
      end
    end
    tx_idx++;
  endtask

  task automatic check_rx_beat();
    string tag;
    logic  exp_last;
    checks++;
    assert (rx_idx < n_in) else begin
      $display("rx_out carried more beats than were sent");
      test_err[T_BP]++;
    end
    if (rx_idx < n_in) begin
      tag      = $sformatf("pkt%0d rx beat%0d", rx_pkt, rx_beat);
      exp_last = (rx_beat == pkt_nin[rx_pkt] - 1);
      check_value(T_TRIP, {tag, " tdata"}, in_data[rx_idx], rx_out.tdata);
      check_value(T_TRIP, {tag, " tkeep"}, 128'(in_keep[rx_idx]), 128'(rx_out.tkeep));
      check_value(T_TRIP, {tag, " tlast"}, 128'(exp_last), 128'(rx_out.tlast));
      check_value(T_SIDE, {tag, " tdest"}, 128'(pkt_dest[rx_pkt]), 128'(rx_out.tdest));
      check_value(T_SIDE, {tag, " tuser"}, 128'(pkt_user[rx_pkt]), 128'(rx_out.tuser));
      if (exp_last) begin
        rx_pkt++;
        rx_beat = 0;
      end else begin
        rx_beat++;
      end
    end
    rx_last_seen += int'(rx_out.tlast);
    rx_idx++;
  endtask

  task automatic check_rx_hdr();
    checks++;
    assert (rh_idx < n_pkts) else begin
      $display("rx_hdr returned more headers than packets were sent");
      test_err[T_HDR]++;
    end
    if (rh_idx < n_pkts) begin
      check_value(T_HDR, $sformatf("pkt%0d header", rh_idx), 128'(pkt_hdr[rh_idx]),
                  128'(rx_hdr));
    end
    rh_idx++;
  endtask

  task automatic report_test(input test_t t);
    if (test_err[t] == 0) begin
      $display("test %s: ok", test_name[t]);
    end else begin
      $display("test %s: %0d errors", test_name[t], test_err[t]);
    end
  endtask

  // transfers seen where valid and ready meet on the edge
  always @(posedge clk) begin
    if (running) begin
      if (tx_out_valid && tx_out_ready) check_tx_beat();
      if (rx_out_valid && rx_out_ready) check_rx_beat();
      if (rx_hdr_valid && rx_hdr_ready) check_rx_hdr();
    end
  end

  // limit scales with the traffic in the file
  initial begin
    @(posedge clk);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: traffic did not drain within %0d cycles", limit_cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int total_err;
    int failed;
    rst          = 1'b1;
    running      = 1'b0;
    tx_hdr       = '0;
    tx_hdr_valid = 1'b0;
    tx_in        = '0;
    tx_in_valid  = 1'b0;
    rx_out_ready = 1'b0;
    rx_hdr_ready = 1'b0;
    void'($urandom(32'hb3c22780));
    load_stimulus();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value(T_RESET, "tx_out_valid", '0, 128'(tx_out_valid));
    check_value(T_RESET, "rx_out_valid", '0, 128'(rx_out_valid));
    check_value(T_RESET, "rx_hdr_valid", '0, 128'(rx_hdr_valid));
    report_test(T_RESET);
    running = 1'b1;
    fork
      stall_outputs();
    join_none
    fork
      drive_headers();
      drive_beats();
    join
    while (tx_idx < n_exp || rx_idx < n_in || rh_idx < n_pkts) @(posedge clk);
    // quiet time so a stray extra beat would still show up
    repeat (20) @(posedge clk);
    check_value(T_BP, "tx beat count", 128'(n_exp), 128'(tx_idx));
    check_value(T_BP, "rx beat count", 128'(n_in), 128'(rx_idx));
    check_value(T_BP, "rx packet count", 128'(n_pkts), 128'(rx_last_seen));
    check_value(T_BP, "header count", 128'(n_pkts), 128'(rh_idx));
    test_err[T_BP] += DUT.u_assertions.fail_count;
    for (int t = T_FRAME; t < T_COUNT; t++) report_test(test_t'(t));
    total_err = 0;
    failed    = 0;
    for (int t = 0; t < T_COUNT; t++) begin
      total_err += test_err[t];
      failed    += int'(test_err[t] != 0);
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             T_COUNT, failed, checks, total_err);
    if (total_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: hdr_frame_stimulus.txt
// each word is 36 hex digits: tkeep[15:0] then tdata[127:0]
// control word: n_in, n_out, tdest, tuser, 48 zero bits, header; then n_in beats, n_out framed
// a control word with n_in = 0 ends the list
// pkt0: one full beat, tail beat needed
01020110000000000000c0de0000000000a0
ffff00112233445566778899aabbccddeeff
ffff8899aabbccddeeffc0de0000000000a0
00ff00000000000000000011223344556677
// pkt1: last beat in the low half only, no tail
02020220000000000000c0de0000000000a1
ffff01010101010101010202020202020202
00ff00000000000000000303030303030303
ffff0202020202020202c0de0000000000a1
ffff03030303030303030101010101010101
// pkt2: last beat of 12 bytes, tail beat needed
03040330000000000000c0de0000000000a2
ffff11111111111111112222222222222222
ffff33333333333333334444444444444444
0fff00000000555555556666666666666666
ffff2222222222222222c0de0000000000a2
ffff44444444444444441111111111111111
ffff66666666666666663333333333333333
000f00000000000000000000000055555555
// pkt3: one beat of 8 bytes, single framed beat
01010440000000000000c0de0000000000a3
00ff00000000000000007777777777777777
ffff7777777777777777c0de0000000000a3
000000000000000000000000000000000000

// File: hdr_frame.f
hdr_frame_pkg.sv
stream_fifo.sv
header_adder.sv
header_remover.sv
hdr_frame_top.sv
hdr_frame_assertions.sv
tb_hdr_frame.sv

// File: run_sim.sh
#!/bin/sh
# build and run the header framing testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_hdr_frame \
  -f hdr_frame.f -o sim_hdr_frame &&
./obj_dir/sim_hdr_frame > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
